/* src.f */
design/limn_pkg.sv
design/limn_ifs.sv
design/limn_decoder.sv
design/limn_regfile.sv
design/limn_alu.sv
design/limn_execute.sv
design/limn_sequencer.sv
design/limn_core.sv
dv/tb_clk_gen.sv
dv/limn_core_chk.sv
dv/limn_core_tb.sv

/* Bender.yml */
package:
  name: limn_core

sources:
  - design/limn_pkg.sv
  - design/limn_ifs.sv
  - design/limn_decoder.sv
  - design/limn_regfile.sv
  - design/limn_alu.sv
  - design/limn_execute.sv
  - design/limn_sequencer.sv
  - design/limn_core.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/limn_core_chk.sv
      - dv/limn_core_tb.sv

/* dv/limn_core_tb.sv */
`timescale 1ns/1ps

module limn_core_tb;

    localparam int MAX_WAIT = 4;

    logic        clk, arst_n, restart;
    logic        rdy, we, cs;
    logic [31:0] data_in, addr, data_out;

    logic [31:0] mem   [256];
    logic [31:0] image [256];                           // Program and data for the next run
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          seed = 79422;
    int          stall_seed = 79422;
    int          wp, wait_left, errors, stores_seen, tests_run, cycles;
    int          cycle_limit = 100;
    bit          stall_en;
    string       cur_name;

    tb_clk_gen u_clk (.restart(restart), .clk(clk), .arst_n(arst_n));

    limn_core uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .rdy      (rdy),
        .data_in  (data_in),
        .addr     (addr),
        .data_out (data_out),
        .we       (we),
        .cs       (cs)
    );

    bind limn_core limn_core_chk u_chk (.*);

    ////////////////////
    // Program building
    ////////////////////
    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] enc(input logic [2:0] cls, input logic [2:0] sub,
                                        input int rd, input int ra, input int imm);
        return {imm[15:0], ra[4:0], rd[4:0], sub, cls};
    endfunction

    function automatic logic [31:0] enc_j(input logic [2:0] cls, input int word);
        return {word[25:0], 3'b000, cls};
    endfunction

    task automatic emit(input logic [31:0] w);
        image[wp] = w;
        wp++;
    endtask

    task automatic new_program();
        for (int k = 0; k < 256; k++)
            image[k] = 32'h5a00_0000 | (k * 32'h0001_0001);
        wp = 0;
    endtask

    // Dump r1..r31 from 0x380 up, then spin
    task automatic end_program();
        for (int r = 1; r < 32; r++)
            emit(enc(limn_pkg::CLS_STORE, 3'd0, r, 0, 'h380 + 4 * (r - 1)));
        emit(enc_j(limn_pkg::CLS_J, wp));
    endtask

    task automatic seed_regs();
        for (int r = 1; r < 13; r++) begin
            emit(enc(limn_pkg::CLS_ALU_I, 3'd0, r, 0, rnd(65536)));        // LUI
            emit(enc(limn_pkg::CLS_ALU_I, limn_pkg::ALU_OR, r, r, rnd(65536)));
        end
    endtask

    task automatic emit_alu_i();
        emit(enc(limn_pkg::CLS_ALU_I, 3'(rnd(8)), rnd(32), rnd(32), rnd(65536)));
    endtask

    function automatic logic [31:0] model_alu(input logic [2:0] op, input logic [31:0] a, b);
        case (op)
            limn_pkg::ALU_NOR:  return ~(a | b);
            limn_pkg::ALU_OR:   return a | b;
            limn_pkg::ALU_XOR:  return a ^ b;
            limn_pkg::ALU_AND:  return a & b;
            limn_pkg::ALU_SLTS: return {31'b0, $signed(a) < $signed(b)};
            limn_pkg::ALU_SLT:  return {31'b0, a < b};
            limn_pkg::ALU_SUB:  return a - b;
            default:            return a + b;
        endcase
    endfunction

    ////////////////////
    // Instruction-set model, fills the expected store list
    ////////////////////
    task automatic run_model(output int n);
        logic [31:0] r [32];
        logic [31:0] m [256];
        logic [31:0] w, a, imm, ea, pc, nxt, tgt;
        foreach (r[i])
            r[i] = '0;
        m = image;
        pc = 32'h0;
        n = 0;
        exp_addr.delete();
        exp_data.delete();
        while (n < 1000) begin
            w   = m[pc[9:2]];
            a   = r[w[15:11]];
            imm = {16'h0, w[31:16]};
            ea  = a + imm;
            tgt = {4'b0, w[31:6], 2'b00};
            nxt = pc + 4;
            n++;
            case (w[2:0])
                limn_pkg::CLS_ALU_R: r[w[10:6]] = model_alu(w[5:3], a, r[w[20:16]] << w[25:21]);
                limn_pkg::CLS_ALU_I:
                    r[w[10:6]] = (w[5:3] == 3'd0) ? (a | (imm << 16)) : model_alu(w[5:3], a, imm);
                limn_pkg::CLS_LOAD:  r[w[10:6]] = m[ea[9:2]];
                limn_pkg::CLS_STORE: begin
                    m[ea[9:2]] = r[w[10:6]];
                    exp_addr.push_back({ea[31:2], 2'b00});
                    exp_data.push_back(r[w[10:6]]);
                end
                limn_pkg::CLS_BRANCH:
                    if ((w[5:3] == limn_pkg::BR_EQ && a == 0) ||
                        (w[5:3] == limn_pkg::BR_NE && a != 0) ||
                        (w[5:3] == limn_pkg::BR_LT && a[31]))
                        nxt = pc + (imm << 2);
                limn_pkg::CLS_JAL: begin
                    r[31] = nxt;
                    nxt   = tgt;
                end
                limn_pkg::CLS_J: begin
                    if (tgt == pc)
                        break;                          // End of program
                    nxt = tgt;
                end
                default: ;
            endcase
            r[0] = '0;
            pc   = nxt;
        end
    endtask

    ////////////////////
    // Memory model and write checks
    ////////////////////
    task automatic check_write(input logic [31:0] wa, input logic [31:0] wd);
        logic [31:0] ea, ed;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("%s: unexpected write of %h to address %h", cur_name, wd, wa);
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            stores_seen++;
            if (wa !== ea) begin
                errors++;
                $display("MISMATCH %s: store address expected %h actual %h", cur_name, ea, wa);
            end
            if (wd !== ed) begin
                errors++;
                $display("MISMATCH %s: store data expected %h actual %h", cur_name, ed, wd);
            end
        end
    endtask

    always @(posedge clk) begin
        if (cs && rdy) begin
            if (we) begin
                check_write(addr, data_out);
                mem[addr[9:2]] = data_out;
            end
            wait_left = stall_en ? $unsigned($random(stall_seed)) % (MAX_WAIT + 1) : 0;
        end else if (cs && wait_left > 0) begin
            wait_left--;
        end
        #1;
        rdy     = (wait_left == 0);
        data_in = mem[addr[9:2]];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles in test %s, the core stopped storing", cycles,
                     cur_name);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////
    // Test runs
    ////////////////////
    task automatic run_test(input string name, input bit stall);
        int n;
        int err0;
        cur_name = name;
        err0     = errors;
        if (tests_run > 0) begin
            @(posedge clk);
            #1 restart = 1'b1;
            #1 restart = 1'b0;
        end
        stall_en = stall;
        mem = image;                                    // Loaded while the core is in reset
        run_model(n);
        cycle_limit += n * 3 * (1 + MAX_WAIT);
        while (!arst_n) begin
            @(posedge clk);
            if (!arst_n && (cs || we)) begin
                errors++;
                $display("%s: cs or we high during reset", name);
            end
        end
        while (!cs)
            @(posedge clk);
        if (we) begin
            errors++;
            $display("%s: first bus cycle after reset is a write", name);
        end
        if (addr !== 32'h0) begin
            errors++;
            $display("MISMATCH %s: first fetch address expected %h actual %h", name,
                     32'h0, addr);
        end
        while (exp_addr.size() != 0)
            @(posedge clk);
        tests_run++;
        $display("Test %s: %0d instructions, %s", name, n, (errors == err0) ? "passed" : "failed");
    endtask

    initial begin
        int k;
        int kind;
        restart  = 1'b0;
        rdy      = 1'b0;
        data_in  = '0;
        stall_en = 1'b0;
        #1;
        new_program();
        end_program();
        run_test("reset_fetch", 1'b0);

        new_program();
        seed_regs();
        for (int i = 0; i < 40; i++)
            emit_alu_i();
        end_program();
        run_test("alu_imm", 1'b0);

        new_program();
        seed_regs();
        for (int i = 0; i < 30; i++)
            emit(enc(limn_pkg::CLS_ALU_R, 3'(rnd(8)), rnd(32), rnd(32), rnd(1024)));
        end_program();
        run_test("alu_reg", 1'b0);

        // Forward branches and jumps over k filler instructions
        new_program();
        seed_regs();
        for (int b = 0; b < 10; b++) begin
            k    = 1 + rnd(3);
            kind = rnd(5);
            if (kind < 3)
                emit(enc(limn_pkg::CLS_BRANCH, 3'(kind), 0, rnd(13), k + 1));
            else
                emit(enc_j((kind == 3) ? limn_pkg::CLS_J : limn_pkg::CLS_JAL, wp + k + 1));
            for (int s = 0; s < k; s++)
                emit_alu_i();
        end
        end_program();
        run_test("branch_jump", 1'b0);

        new_program();
        for (int i = 128; i < 192; i++)
            image[i] = $random(seed);
        emit(enc(limn_pkg::CLS_ALU_I, limn_pkg::ALU_OR, 1, 0, 'h200));   // r1 is the data base
        for (int i = 0; i < 24; i++) begin
            kind = rnd(3);
            if (kind == 0)
                emit(enc(limn_pkg::CLS_LOAD, 3'd0, 2 + rnd(30), 1, rnd(256)));
            else if (kind == 1)
                emit(enc(limn_pkg::CLS_STORE, 3'd0, rnd(32), 1, 'h100 + rnd(128)));
            else
                emit(enc(limn_pkg::CLS_ALU_R, 3'(rnd(8)), 2 + rnd(30), 2 + rnd(30),
                         (rnd(4) << 5) | (2 + rnd(30))));
        end
        end_program();
        run_test("load_store", 1'b0);
        run_test("back_pressure", 1'b1);                // Same image, random rdy stalls

        $display("Tests run %0d, stores checked %0d, errors %0d", tests_run, stores_seen, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* dv/limn_core_chk.sv */
`timescale 1ns/1ps

module limn_core_chk (
    input logic        clk,
    input logic        arst_n,
    input logic        rdy,
    input logic        cs,
    input logic        we,
    input logic [31:0] addr,
    input logic [31:0] data_out
);

    ////////////////////
    // Bus rules
    ////////////////////
    a_we_in_cycle: assert property (@(posedge clk) disable iff (!arst_n) we |-> cs)
        else $error("we is high while cs is low");

    // Request held until the memory answers
    a_hold_on_wait: assert property (@(posedge clk) disable iff (!arst_n)
        (cs && !rdy) |=> ($stable(addr) && $stable(we) && $stable(data_out)))
        else $error("bus request changed while rdy was low");

    a_quiet_reset: assert property (@(posedge clk) !arst_n |-> (!cs && !we))
        else $error("cs or we high during reset");

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    input  logic restart,
    output logic clk,
    output logic arst_n
);

    initial clk = 1'b0;
    always #2 clk = ~clk;                               // 4 ns period

    // Reset for 5 cycles at start and again on each restart pulse
    always begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge restart);
    end

endmodule

/* design/limn_core.sv */
`timescale 1ns/1ps

module limn_core (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      rdy,
    input  logic [limn_pkg::XLEN-1:0] data_in,
    output logic [limn_pkg::XLEN-1:0] addr,
    output logic [limn_pkg::XLEN-1:0] data_out,
    output logic                      we,
    output logic                      cs
);

    limn_pkg::insn_u           insn;
    logic [limn_pkg::XLEN-1:0] pc;
    logic [limn_pkg::XLEN-1:0] alu_result;
    logic                      take_branch;
    logic [limn_pkg::XLEN-1:0] next_pc;
    logic [limn_pkg::XLEN-1:0] mem_addr;
    logic [limn_pkg::XLEN-1:0] store_data;

    dec_if dec ();
    rf_if  rf ();

    ////////////////////
    // Units
    ////////////////////
    limn_sequencer u_seq (
        .clk         (clk),
        .arst_n      (arst_n),
        .rdy         (rdy),
        .data_in     (data_in),
        .addr        (addr),
        .data_out    (data_out),
        .we          (we),
        .cs          (cs),
        .insn        (insn),
        .pc          (pc),
        .dec         (dec.receiver),
        .rf          (rf.writer),
        .alu_result  (alu_result),
        .take_branch (take_branch),
        .next_pc     (next_pc),
        .mem_addr    (mem_addr),
        .store_data  (store_data)
    );

    limn_decoder u_dec (
        .insn (insn),
        .dec  (dec.driver)
    );

    limn_regfile u_rf (
        .clk    (clk),
        .arst_n (arst_n),
        .rf     (rf.regfile)
    );

    limn_execute u_exe (
        .dec         (dec.receiver),
        .rf          (rf.reader),
        .pc          (pc),
        .alu_result  (alu_result),
        .take_branch (take_branch),
        .next_pc     (next_pc),
        .mem_addr    (mem_addr),
        .store_data  (store_data)
    );

endmodule

/* design/limn_sequencer.sv */
`timescale 1ns/1ps

module limn_sequencer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      rdy,
    input  logic [limn_pkg::XLEN-1:0] data_in,
    output logic [limn_pkg::XLEN-1:0] addr,
    output logic [limn_pkg::XLEN-1:0] data_out,
    output logic                      we,
    output logic                      cs,
    output limn_pkg::insn_u           insn,
    output logic [limn_pkg::XLEN-1:0] pc,
    dec_if.receiver                   dec,
    rf_if.writer                      rf,
    input  logic [limn_pkg::XLEN-1:0] alu_result,
    input  logic                      take_branch,
    input  logic [limn_pkg::XLEN-1:0] next_pc,
    input  logic [limn_pkg::XLEN-1:0] mem_addr,
    input  logic [limn_pkg::XLEN-1:0] store_data
);

    logic [1:0]                state;
    logic                      mem_op;
    logic                      mem_done;
    logic [limn_pkg::XLEN-1:0] pc_commit;

    assign mem_op    = dec.is_load | dec.is_store;
    assign mem_done  = (state == limn_pkg::ST_MEM) & rdy;
    assign pc_commit = take_branch ? next_pc : pc + 32'd4;

    ////////////////////
    // Retire write-back
    ////////////////////
    assign rf.wr_en = ((state == limn_pkg::ST_EXEC) &
                       (dec.is_alu_r | dec.is_alu_i | dec.is_link)) |
                      (mem_done & dec.is_load);
    assign rf.wr_idx  = dec.rd;
    assign rf.wr_data = (state == limn_pkg::ST_MEM) ? data_in : alu_result;

    ////////////////////
    // State, pc and bus control
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= limn_pkg::ST_FETCH;
            pc    <= limn_pkg::RESET_PC;
            cs    <= 1'b0;
            we    <= 1'b0;
            insn  <= limn_pkg::INSN_NOP;
        end else begin
            case (state)
                limn_pkg::ST_FETCH: begin
                    if (!cs) begin
                        cs <= 1'b1;                     // Only right after reset
                    end else if (rdy) begin
                        insn  <= data_in;
                        cs    <= 1'b0;
                        state <= limn_pkg::ST_EXEC;
                    end
                end
                limn_pkg::ST_EXEC: begin
                    cs <= 1'b1;                         // Next phase starts now
                    if (mem_op) begin
                        we    <= dec.is_store;
                        state <= limn_pkg::ST_MEM;
                    end else begin
                        pc    <= pc_commit;
                        state <= limn_pkg::ST_FETCH;
                    end
                end
                limn_pkg::ST_MEM: begin
                    if (rdy) begin
                        we    <= 1'b0;                  // cs stays up for the fetch
                        pc    <= pc_commit;
                        state <= limn_pkg::ST_FETCH;
                    end
                end
                default: state <= limn_pkg::ST_FETCH;
            endcase
        end
    end

    // Address and write data, held while waiting on rdy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr     <= '0;
            data_out <= '0;
        end else if ((state == limn_pkg::ST_FETCH) && !cs) begin
            addr <= pc;
        end else if (state == limn_pkg::ST_EXEC) begin
            if (mem_op) begin
                addr     <= mem_addr;
                data_out <= store_data;
            end else begin
                addr <= pc_commit;
            end
        end else if (mem_done) begin
            addr <= pc_commit;
        end
    end

endmodule

/* design/limn_execute.sv */
`timescale 1ns/1ps

module limn_execute (
    dec_if.receiver                   dec,
    rf_if.reader                      rf,
    input  logic [limn_pkg::XLEN-1:0] pc,
    output logic [limn_pkg::XLEN-1:0] alu_result,
    output logic                      take_branch,
    output logic [limn_pkg::XLEN-1:0] next_pc,     // Redirect target
    output logic [limn_pkg::XLEN-1:0] mem_addr,
    output logic [limn_pkg::XLEN-1:0] store_data
);

    localparam int W = limn_pkg::XLEN;

    logic [W-1:0] imm_ext;
    logic [W-1:0] alu_b;
    logic [W-1:0] alu_y;
    logic [W-1:0] pc_plus4;
    logic [W-1:0] eff_addr;
    logic         cond_hit;

    // Stores read the data register through port b
    assign rf.ra_idx = dec.ra;
    assign rf.rb_idx = dec.is_store ? dec.rd : dec.rb;

    assign imm_ext = {{(W-16){1'b0}}, dec.imm16};
    assign alu_b   = dec.is_alu_i ? imm_ext : (rf.rb_data << dec.shamt);

    limn_alu u_alu (
        .op  (dec.sub_op),
        .lui (dec.is_lui),
        .a   (rf.ra_data),
        .b   (alu_b),
        .y   (alu_y)
    );

    assign pc_plus4   = pc + 32'd4;
    assign alu_result = dec.is_link ? pc_plus4 : alu_y;  // JAL link value

    ////////////////////
    // Branch decision
    ////////////////////
    always_comb begin
        case (dec.sub_op)
            limn_pkg::BR_EQ: cond_hit = (rf.ra_data == '0);
            limn_pkg::BR_NE: cond_hit = (rf.ra_data != '0);
            limn_pkg::BR_LT: cond_hit = rf.ra_data[W-1];
            default:         cond_hit = 1'b0;
        endcase
    end

    assign take_branch = (dec.is_branch & cond_hit) | dec.is_jump;
    assign next_pc = dec.is_jump ? {{(W-28){1'b0}}, dec.target, 2'b00}
                                 : pc + (imm_ext << 2);

    // Word access, low two bits dropped
    assign eff_addr   = rf.ra_data + imm_ext;
    assign mem_addr   = {eff_addr[W-1:2], 2'b00};
    assign store_data = rf.rb_data;

endmodule

/* design/limn_alu.sv */
`timescale 1ns/1ps

module limn_alu (
    input  logic [2:0]                op,
    input  logic                      lui,
    input  logic [limn_pkg::XLEN-1:0] a,
    input  logic [limn_pkg::XLEN-1:0] b,
    output logic [limn_pkg::XLEN-1:0] y
);

    localparam int W = limn_pkg::XLEN;

    always_comb begin
        if (lui) begin
            y = a | (b << 16);                          // Upper half from imm
        end else begin
            case (op)
                limn_pkg::ALU_NOR:  y = ~(a | b);
                limn_pkg::ALU_OR:   y = a | b;
                limn_pkg::ALU_XOR:  y = a ^ b;
                limn_pkg::ALU_AND:  y = a & b;
                limn_pkg::ALU_SLTS: y = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
                limn_pkg::ALU_SLT:  y = {{(W-1){1'b0}}, a < b};
                limn_pkg::ALU_SUB:  y = a - b;
                limn_pkg::ALU_ADD:  y = a + b;
            endcase
        end
    end

endmodule

/* design/limn_regfile.sv */
`timescale 1ns/1ps

module limn_regfile (
    input  logic clk,
    input  logic arst_n,
    rf_if.regfile rf
);

    logic [limn_pkg::XLEN-1:0] regs [limn_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < limn_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && (rf.wr_idx != '0)) begin  // r0 writes dropped
            regs[rf.wr_idx] <= rf.wr_data;
        end
    end

    // Combinational reads, r0 hardwired
    assign rf.ra_data = (rf.ra_idx == '0) ? '0 : regs[rf.ra_idx];
    assign rf.rb_data = (rf.rb_idx == '0) ? '0 : regs[rf.rb_idx];

endmodule

/* design/limn_decoder.sv */
`timescale 1ns/1ps

module limn_decoder (
    input  limn_pkg::insn_u insn,
    dec_if.driver           dec
);

    ////////////////////
    // Class strobes
    ////////////////////
    always_comb begin
        dec.is_alu_r  = 1'b0;
        dec.is_alu_i  = 1'b0;
        dec.is_lui    = 1'b0;
        dec.is_load   = 1'b0;
        dec.is_store  = 1'b0;
        dec.is_branch = 1'b0;
        dec.is_jump   = 1'b0;
        dec.is_link   = 1'b0;
        case (insn.i_fmt.cls)
            limn_pkg::CLS_NOP:    ;                        // Nothing raised
            limn_pkg::CLS_ALU_R:  dec.is_alu_r = 1'b1;
            limn_pkg::CLS_STORE:  dec.is_store = 1'b1;
            limn_pkg::CLS_LOAD:   dec.is_load  = 1'b1;
            limn_pkg::CLS_ALU_I: begin
                dec.is_alu_i = 1'b1;
                // Sub-op 000 is LUI here, not NOR
                dec.is_lui   = (insn.i_fmt.sub_op == 3'b000);
            end
            limn_pkg::CLS_BRANCH: dec.is_branch = 1'b1;
            limn_pkg::CLS_J:      dec.is_jump   = 1'b1;
            limn_pkg::CLS_JAL: begin
                dec.is_jump = 1'b1;
                dec.is_link = 1'b1;
            end
        endcase
    end

    ////////////////////
    // Fields
    ////////////////////
    assign dec.sub_op = insn.i_fmt.sub_op;
    assign dec.ra     = insn.i_fmt.ra;
    assign dec.rb     = insn.r_fmt.rb;
    assign dec.shamt  = insn.r_fmt.shamt;
    assign dec.imm16  = insn.i_fmt.imm16;
    assign dec.target = insn.j_fmt.target;

    // JAL writes the link register, whatever bits 10:6 hold
    assign dec.rd = (insn.j_fmt.cls == limn_pkg::CLS_JAL) ? limn_pkg::REG_LR
                                                           : insn.i_fmt.rd;

endmodule

/* design/limn_ifs.sv */
`timescale 1ns/1ps

// Decoded fields of the held instruction
interface dec_if;
    logic is_alu_r, is_alu_i, is_lui, is_load;
    logic is_store, is_branch, is_jump, is_link;
    logic [2:0]                     sub_op;
    logic [limn_pkg::REG_IDX_W-1:0] rd, ra, rb;
    logic [4:0]                     shamt;
    logic [15:0]                    imm16;
    logic [25:0]                    target;

    modport driver (output is_alu_r, is_alu_i, is_lui, is_load, is_store, is_branch,
                    is_jump, is_link, sub_op, rd, ra, rb, shamt, imm16, target);
    modport receiver (input is_alu_r, is_alu_i, is_lui, is_load, is_store, is_branch,
                      is_jump, is_link, sub_op, rd, ra, rb, shamt, imm16, target);
endinterface

// Two read ports, one write port
interface rf_if;
    logic [limn_pkg::REG_IDX_W-1:0] ra_idx, rb_idx;
    logic [limn_pkg::XLEN-1:0]      ra_data, rb_data;
    logic                           wr_en;
    logic [limn_pkg::REG_IDX_W-1:0] wr_idx;
    logic [limn_pkg::XLEN-1:0]      wr_data;

    modport regfile (input ra_idx, rb_idx, wr_en, wr_idx, wr_data,
                     output ra_data, rb_data);
    modport reader (output ra_idx, rb_idx, input ra_data, rb_data);
    modport writer (output wr_en, wr_idx, wr_data);
endinterface

/* design/limn_pkg.sv */
package limn_pkg;

    ////////////////////
    // Widths and fixed values
    ////////////////////
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    localparam logic [REG_IDX_W-1:0] REG_LR = 5'd31;      // Link register for JAL
    localparam logic [XLEN-1:0]      RESET_PC = 32'h0;
    localparam logic [31:0]          INSN_NOP = 32'h0;    // Internal true no-op

    ////////////////////
    // Instruction classes, bits 2:0
    ////////////////////
    localparam logic [2:0] CLS_NOP    = 3'b000;
    localparam logic [2:0] CLS_ALU_R  = 3'b001;
    localparam logic [2:0] CLS_STORE  = 3'b010;
    localparam logic [2:0] CLS_LOAD   = 3'b011;
    localparam logic [2:0] CLS_ALU_I  = 3'b100;
    localparam logic [2:0] CLS_BRANCH = 3'b101;
    localparam logic [2:0] CLS_J      = 3'b110;
    localparam logic [2:0] CLS_JAL    = 3'b111;

    // ALU ops, sub-op field bits 5:3
    localparam logic [2:0] ALU_NOR  = 3'b000;             // LUI in the immediate class
    localparam logic [2:0] ALU_OR   = 3'b001;
    localparam logic [2:0] ALU_XOR  = 3'b010;
    localparam logic [2:0] ALU_AND  = 3'b011;
    localparam logic [2:0] ALU_SLTS = 3'b100;
    localparam logic [2:0] ALU_SLT  = 3'b101;
    localparam logic [2:0] ALU_SUB  = 3'b110;
    localparam logic [2:0] ALU_ADD  = 3'b111;

    // Branch conditions on ra
    localparam logic [2:0] BR_EQ = 3'b000;
    localparam logic [2:0] BR_NE = 3'b001;
    localparam logic [2:0] BR_LT = 3'b010;

    // Sequencer states
    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_MEM   = 2'd2;

    ////////////////////
    // Instruction word views
    ////////////////////
    typedef union packed {
        struct packed {
            logic [15:0]          imm16;
            logic [REG_IDX_W-1:0] ra;
            logic [REG_IDX_W-1:0] rd;
            logic [2:0]           sub_op;
            logic [2:0]           cls;
        } i_fmt;
        struct packed {
            logic [5:0]           rsvd;
            logic [4:0]           shamt;
            logic [REG_IDX_W-1:0] rb;
            logic [REG_IDX_W-1:0] ra;
            logic [REG_IDX_W-1:0] rd;
            logic [2:0]           sub_op;
            logic [2:0]           cls;
        } r_fmt;
        struct packed {
            logic [25:0]          target;  // Word address
            logic [2:0]           sub_op;
            logic [2:0]           cls;
        } j_fmt;
    } insn_u;

endpackage
